//--- source/narrator_config.svh
`ifndef NARRATOR_CONFIG_SVH
`define NARRATOR_CONFIG_SVH

// ==================================================
// Bus and sample widths
// ==================================================
`define NARR_ADDR_W 23
`define NARR_DATA_W 32
`define NARR_AUDIO_W 8
`define NARR_DIV_W 16

// Playback buffer, also the reader's starting credit
`define NARR_FIFO_DEPTH 4

// ==================================================
// Sample divisor limits, in CLK_50M cycles
// ==================================================
`define NARR_DIV_DEFAULT 64
`define NARR_DIV_STEP 8
`define NARR_DIV_MIN 16
`define NARR_DIV_MAX 240

// Phoneme table geometry in flash words
`define NARR_PHONEME_STRIDE 8
`define NARR_LOWEST_PHONEME_WORDS 2

`endif

//--- source/narrator_pkg.sv
`include "narrator_config.svh"

package narrator_pkg;

  // ==================================================
  // Data widths
  // ==================================================
  typedef logic [`NARR_ADDR_W-1:0] flash_addr_t;
  typedef logic [`NARR_DATA_W-1:0] flash_word_t;
  typedef logic signed [`NARR_AUDIO_W-1:0] audio_sample_t;
  typedef logic [`NARR_DIV_W-1:0] sample_div_t;
  typedef logic [7:0] ascii_t;

  // ==================================================
  // State machines
  // ==================================================
  // Phoneme sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_PLAY
  } seq_state_t;

  // Flash read master
  typedef enum logic [1:0] {
    RD_IDLE,
    RD_REQ,
    RD_DRAIN
  } rd_state_t;

endpackage

//--- source/narrator_ifs.sv
`timescale 1ns/1ps

// Phoneme descriptor from the sequencer, done back from the player
interface phoneme_if;
  logic start_pulse;
  narrator_pkg::flash_addr_t start_addr;
  narrator_pkg::flash_addr_t last_addr;
  logic silent;
  logic done;

  modport seq (
    output start_pulse,
    output start_addr,
    output last_addr,
    output silent,
    input done
  );

  modport reader (
    input start_pulse,
    input start_addr,
    input last_addr
  );

  modport player (
    input start_pulse,
    input silent,
    output done
  );
endinterface

// Word stream from the flash reader, credits flow back
interface word_credit_if;
  logic word_valid;
  narrator_pkg::flash_word_t word_data;
  logic word_last;
  logic credit;

  modport reader (
    output word_valid,
    output word_data,
    output word_last,
    input credit
  );

  modport player (
    input word_valid,
    input word_data,
    input word_last,
    output credit
  );
endinterface

//--- source/phoneme_sequencer.sv
`timescale 1ns/1ps
`include "narrator_config.svh"

module phoneme_sequencer (
  input logic CLK_50M,
  input logic arst_n,
  input logic key_valid,
  input narrator_pkg::ascii_t key_char,
  output logic key_ready,
  phoneme_if.seq ph
);

  narrator_pkg::seq_state_t state;
  narrator_pkg::ascii_t char_off;
  logic [4:0] letter_idx;
  logic is_letter;
  logic is_space;
  logic accept;
  narrator_pkg::flash_addr_t map_start;
  narrator_pkg::flash_addr_t map_last;

  // ==================================================
  // Character to phoneme range
  // ==================================================
  assign char_off = key_char - 8'h61;
  assign letter_idx = char_off[4:0];
  assign is_letter = (key_char >= 8'h61) && (key_char <= 8'h7a);
  assign is_space = (key_char == 8'h20);

  // Space reuses phoneme 0, so index zero gives its range too
  always_comb
  begin
    map_start = narrator_pkg::flash_addr_t'(is_letter ? letter_idx : 5'd0)
      * narrator_pkg::flash_addr_t'(`NARR_PHONEME_STRIDE);
    map_last = map_start
      + narrator_pkg::flash_addr_t'(`NARR_LOWEST_PHONEME_WORDS - 1)
      + narrator_pkg::flash_addr_t'(is_letter ? letter_idx[1:0] : 2'd0);
  end

  assign key_ready = (state == narrator_pkg::SEQ_IDLE);
  assign accept = key_valid && key_ready && (is_letter || is_space);
  assign ph.start_pulse = (state == narrator_pkg::SEQ_ISSUE);

  // Descriptor held steady for the whole phoneme
  always_ff @(posedge CLK_50M)
  begin
    if (accept)
    begin
      ph.start_addr <= map_start;
      ph.last_addr <= map_last;
      ph.silent <= is_space;
    end
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      state <= narrator_pkg::SEQ_IDLE;
    else
    begin
      case (state)
        narrator_pkg::SEQ_IDLE:  if (accept) state <= narrator_pkg::SEQ_ISSUE;
        narrator_pkg::SEQ_ISSUE: state <= narrator_pkg::SEQ_PLAY;
        narrator_pkg::SEQ_PLAY:  if (ph.done) state <= narrator_pkg::SEQ_IDLE;
        default:                 state <= narrator_pkg::SEQ_IDLE;
      endcase
    end
  end

  // Player only finishes a phoneme this sequencer started
  a_done_in_play: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    ph.done |-> state == narrator_pkg::SEQ_PLAY);

endmodule

//--- source/flash_reader.sv
`timescale 1ns/1ps
`include "narrator_config.svh"

module flash_reader (
  input logic CLK_50M,
  input logic arst_n,
  phoneme_if.reader ph,
  word_credit_if.reader wc,
  output logic flash_read,
  output narrator_pkg::flash_addr_t flash_address,
  input logic flash_waitrequest,
  input narrator_pkg::flash_word_t flash_readdata,
  input logic flash_readdatavalid
);

  localparam int CRED_W = $clog2(`NARR_FIFO_DEPTH + 1);
  localparam logic [CRED_W-1:0] CRED_FULL = CRED_W'(`NARR_FIFO_DEPTH);

  narrator_pkg::rd_state_t state;
  narrator_pkg::flash_addr_t cur_addr;
  logic [CRED_W-1:0] credit_cnt;
  logic last_pending;
  logic issue;

  assign flash_read = (state == narrator_pkg::RD_REQ) && (credit_cnt != '0);
  assign flash_address = cur_addr;
  assign issue = flash_read && !flash_waitrequest;

  // Returned words go straight to the player
  assign wc.word_valid = (state == narrator_pkg::RD_DRAIN) && flash_readdatavalid;
  assign wc.word_data = flash_readdata;
  assign wc.word_last = last_pending;

  // ==================================================
  // Credit counter
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      credit_cnt <= CRED_FULL;
    else if (issue && !wc.credit)
      credit_cnt <= credit_cnt - 1'b1;
    else if (!issue && wc.credit)
      credit_cnt <= credit_cnt + 1'b1;
  end

  // ==================================================
  // Read FSM, one read outstanding at a time
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= narrator_pkg::RD_IDLE;
      cur_addr <= '0;
      last_pending <= 1'b0;
    end
    else
    begin
      case (state)
        narrator_pkg::RD_IDLE:
        begin
          if (ph.start_pulse)
          begin
            cur_addr <= ph.start_addr;
            state <= narrator_pkg::RD_REQ;
          end
        end
        narrator_pkg::RD_REQ:
        begin
          if (issue)
          begin
            last_pending <= (cur_addr == ph.last_addr);
            state <= narrator_pkg::RD_DRAIN;
          end
        end
        narrator_pkg::RD_DRAIN:
        begin
          if (flash_readdatavalid)
          begin
            cur_addr <= cur_addr + 1'b1;
            state <= last_pending ? narrator_pkg::RD_IDLE : narrator_pkg::RD_REQ;
          end
        end
        default: state <= narrator_pkg::RD_IDLE;
      endcase
    end
  end

  a_credit_bound: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    credit_cnt <= CRED_FULL);

  // Avalon rule: a stalled read keeps its address
  a_addr_hold: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address));

endmodule

//--- source/sample_player.sv
`timescale 1ns/1ps
`include "narrator_config.svh"

module sample_player (
  input logic CLK_50M,
  input logic arst_n,
  phoneme_if.player ph,
  word_credit_if.player wc,
  input logic sample_tick,
  output narrator_pkg::audio_sample_t audio_sample,
  output logic sample_strobe
);

  localparam int PTR_W = $clog2(`NARR_FIFO_DEPTH);
  localparam int BIT_W = $clog2(`NARR_DATA_W);

  narrator_pkg::flash_word_t word_mem [`NARR_FIFO_DEPTH];
  logic last_mem [`NARR_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0] fifo_cnt;
  narrator_pkg::flash_word_t shift_reg;
  logic [BIT_W-1:0] bit_cnt;
  logic loaded;
  logic cur_last;
  logic silent_q;
  logic word_end;
  logic pop;

  assign word_end = sample_tick && loaded && (bit_cnt == BIT_W'(`NARR_DATA_W - 1));
  // Refill as the current word ends, so no tick is lost in between
  assign pop = (fifo_cnt != '0) && (!loaded || word_end);

  // ==================================================
  // Word FIFO
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (wc.word_valid)
    begin
      word_mem[wr_ptr] <= wc.word_data;
      last_mem[wr_ptr] <= wc.word_last;
    end
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fifo_cnt <= '0;
    end
    else
    begin
      if (wc.word_valid)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wc.word_valid, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
    end
  end

  // ==================================================
  // Serializer, LSB first
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (pop)
    begin
      shift_reg <= word_mem[rd_ptr];
      cur_last <= last_mem[rd_ptr];
    end
    else if (sample_tick && loaded)
      shift_reg <= shift_reg >> 1;
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      loaded <= 1'b0;
      bit_cnt <= '0;
      silent_q <= 1'b0;
      wc.credit <= 1'b0;
      ph.done <= 1'b0;
    end
    else
    begin
      wc.credit <= word_end;
      ph.done <= word_end && cur_last;
      if (ph.start_pulse)
        silent_q <= ph.silent;
      if (pop)
      begin
        loaded <= 1'b1;
        bit_cnt <= '0;
      end
      else if (word_end)
        loaded <= 1'b0;
      else if (sample_tick && loaded)
        bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // 1 maps to +127 and 0 to -128
  assign audio_sample = (!loaded || silent_q) ? '0
    : narrator_pkg::audio_sample_t'({~shift_reg[0], {(`NARR_AUDIO_W - 1){shift_reg[0]}}});
  assign sample_strobe = sample_tick && loaded;

  // Credits upstream keep the buffer from overflowing
  a_no_overflow: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    wc.word_valid |-> fifo_cnt != (PTR_W + 1)'(`NARR_FIFO_DEPTH));

endmodule

//--- source/sample_rate_ctrl.sv
`timescale 1ns/1ps
`include "narrator_config.svh"

module sample_rate_ctrl (
  input logic CLK_50M,
  input logic arst_n,
  input logic btn_up,
  input logic btn_down,
  input logic btn_reset,
  output logic sample_tick,
  output narrator_pkg::sample_div_t sample_div
);

  logic [2:0] btn_meta;
  logic [2:0] btn_sync;
  logic [2:0] btn_prev;
  logic [2:0] btn_rise;
  narrator_pkg::sample_div_t tick_cnt;

  // ==================================================
  // Button synchronizers and edge detect
  // ==================================================
  // Bit 0 up, bit 1 down, bit 2 reset
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      btn_meta <= '0;
      btn_sync <= '0;
      btn_prev <= '0;
    end
    else
    begin
      btn_meta <= {btn_reset, btn_down, btn_up};
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;
    end
  end

  assign btn_rise = btn_sync & ~btn_prev;

  // Divisor register, saturating at both ends
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      sample_div <= `NARR_DIV_W'(`NARR_DIV_DEFAULT);
    else if (btn_rise[2])
      sample_div <= `NARR_DIV_W'(`NARR_DIV_DEFAULT);
    else if (btn_rise[0])
      sample_div <= (sample_div <= `NARR_DIV_W'(`NARR_DIV_MIN + `NARR_DIV_STEP))
        ? `NARR_DIV_W'(`NARR_DIV_MIN) : sample_div - `NARR_DIV_W'(`NARR_DIV_STEP);
    else if (btn_rise[1])
      sample_div <= (sample_div >= `NARR_DIV_W'(`NARR_DIV_MAX - `NARR_DIV_STEP))
        ? `NARR_DIV_W'(`NARR_DIV_MAX) : sample_div + `NARR_DIV_W'(`NARR_DIV_STEP);
  end

  // ==================================================
  // Tick generator
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt >= sample_div - 1'b1)
    begin
      tick_cnt <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt <= tick_cnt + 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

//--- source/narrator_top.sv
`timescale 1ns/1ps

module narrator_top (
  input logic CLK_50M,
  input logic arst_n,

  // Character input
  input logic key_valid,
  input narrator_pkg::ascii_t key_char,
  output logic key_ready,

  // Speed buttons, active high
  input logic btn_up,
  input logic btn_down,
  input logic btn_reset,

  // Avalon flash read bus
  output logic flash_read,
  output narrator_pkg::flash_addr_t flash_address,
  input logic flash_waitrequest,
  input narrator_pkg::flash_word_t flash_readdata,
  input logic flash_readdatavalid,

  // Audio out and current divisor
  output narrator_pkg::audio_sample_t audio_sample,
  output logic sample_strobe,
  output narrator_pkg::sample_div_t sample_div
);

  logic sample_tick;

  phoneme_if ph0 ();
  word_credit_if wc0 ();

  phoneme_sequencer seq0 (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .key_valid (key_valid),
    .key_char (key_char),
    .key_ready (key_ready),
    .ph (ph0.seq)
  );

  flash_reader rd0 (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .ph (ph0.reader),
    .wc (wc0.reader),
    .flash_read (flash_read),
    .flash_address (flash_address),
    .flash_waitrequest (flash_waitrequest),
    .flash_readdata (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  sample_player play0 (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .ph (ph0.player),
    .wc (wc0.player),
    .sample_tick (sample_tick),
    .audio_sample (audio_sample),
    .sample_strobe (sample_strobe)
  );

  sample_rate_ctrl rate0 (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .btn_up (btn_up),
    .btn_down (btn_down),
    .btn_reset (btn_reset),
    .sample_tick (sample_tick),
    .sample_div (sample_div)
  );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic CLK_50M,
  output logic arst_n
);

  // 50 MHz, 20 ns period
  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  initial
  begin
    arst_n = 1'b0;
    repeat (8) @(posedge CLK_50M);
    @(negedge CLK_50M);
    arst_n = 1'b1;
  end

endmodule

//--- verification/narrator_tb.sv
`timescale 1ns/1ps
`include "narrator_config.svh"

module narrator_tb;

  logic CLK_50M;
  logic arst_n;
  logic key_valid;
  narrator_pkg::ascii_t key_char;
  logic key_ready;
  logic btn_up;
  logic btn_down;
  logic btn_reset;
  logic flash_read;
  narrator_pkg::flash_addr_t flash_address;
  logic flash_waitrequest = 1'b0;
  narrator_pkg::flash_word_t flash_readdata = '0;
  logic flash_readdatavalid = 1'b0;
  narrator_pkg::audio_sample_t audio_sample;
  logic sample_strobe;
  narrator_pkg::sample_div_t sample_div;

  // Flash model state
  logic [31:0] rng_state = 32'd24;
  int stall_max = 3;
  logic pending = 1'b0;
  logic accept_armed = 1'b0;
  logic req_active = 1'b0;
  int wr_wait = 0;
  int data_wait = 0;
  narrator_pkg::flash_addr_t pend_addr = '0;
  narrator_pkg::flash_addr_t armed_addr = '0;

  narrator_pkg::flash_addr_t accepted_q[$];
  narrator_pkg::audio_sample_t sample_q[$];
  int strobe_cyc_q[$];
  int cycle = 0;

  tb_clock_gen clk0 (.CLK_50M (CLK_50M), .arst_n (arst_n));

  narrator_top dut0 (.*);

  always @(posedge CLK_50M) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function int draw_delay();
    rng_state = xorshift32(rng_state);
    return int'(rng_state % 32'(stall_max + 1));
  endfunction

  function automatic narrator_pkg::flash_word_t word_at(input narrator_pkg::flash_addr_t a);
    return narrator_pkg::flash_word_t'(a) ^ 32'hA5C3_0000;
  endfunction

  // ==================================================
  // Flash model, driven on the falling edge
  // ==================================================
  always @(negedge CLK_50M)
  begin
    if (arst_n)
    begin
      flash_readdatavalid = 1'b0;
      // Read accepted at the rising edge just passed
      if (accept_armed)
      begin
        pending = 1'b1;
        pend_addr = armed_addr;
        data_wait = draw_delay();
        accepted_q.push_back(armed_addr);
      end
      accept_armed = 1'b0;
      if (pending)
      begin
        if (data_wait == 0)
        begin
          flash_readdatavalid = 1'b1;
          flash_readdata = word_at(pend_addr);
          pending = 1'b0;
        end
        else
          data_wait = data_wait - 1;
      end
      if (flash_read)
      begin
        if (!req_active)
        begin
          req_active = 1'b1;
          wr_wait = draw_delay();
        end
        if (wr_wait != 0)
        begin
          flash_waitrequest = 1'b1;
          wr_wait = wr_wait - 1;
        end
        else
        begin
          flash_waitrequest = 1'b0;
          accept_armed = 1'b1;
          armed_addr = flash_address;
          req_active = 1'b0;
        end
      end
      else
      begin
        flash_waitrequest = 1'b0;
        req_active = 1'b0;
      end
    end
  end

  // Strobed samples with their cycle number
  always @(negedge CLK_50M)
  begin
    if (arst_n && sample_strobe)
    begin
      sample_q.push_back(audio_sample);
      strobe_cyc_q.push_back(cycle);
    end
  end

  // ==================================================
  // Failure reporting and checks
  // ==================================================
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_sample(input string name, input narrator_pkg::audio_sample_t got,
                              input narrator_pkg::audio_sample_t exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic check_div(input string name, input narrator_pkg::sample_div_t got,
                           input narrator_pkg::sample_div_t exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic check_addr(input string name, input narrator_pkg::flash_addr_t got,
                            input narrator_pkg::flash_addr_t exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp));
  endtask

  task automatic wait_key_ready(input int limit);
    int n;
    n = 0;
    while (!key_ready)
    begin
      @(negedge CLK_50M);
      n++;
      if (n > limit)
        abort_run("Timed out waiting for key_ready to return high");
    end
  endtask

  task automatic send_key(input narrator_pkg::ascii_t c);
    wait_key_ready(1000);
    key_char = c;
    key_valid = 1'b1;
    @(negedge CLK_50M);
    key_valid = 1'b0;
    key_char = '0;
  endtask

  task automatic press_button(input int which);
    btn_up = (which == 0);
    btn_down = (which == 1);
    btn_reset = (which == 2);
    // Two synchronizer flops plus edge detect settle within this
    repeat (4) @(negedge CLK_50M);
    btn_up = 1'b0;
    btn_down = 1'b0;
    btn_reset = 1'b0;
    repeat (4) @(negedge CLK_50M);
  endtask

  // Plays one character and checks addresses and samples
  task automatic play_range(input narrator_pkg::ascii_t c, input narrator_pkg::flash_addr_t first,
                            input int nwords, input logic silent);
    int k;
    int b;
    narrator_pkg::flash_word_t w;
    narrator_pkg::audio_sample_t exp;
    accepted_q.delete();
    sample_q.delete();
    strobe_cyc_q.delete();
    send_key(c);
    check_bit("key_ready", key_ready, 1'b0);
    wait_key_ready(200000);
    if (accepted_q.size() != nwords)
      abort_run($sformatf("Expected %0d flash reads but saw %0d", nwords, accepted_q.size()));
    for (k = 0; k < nwords; k++)
      check_addr("flash_address", accepted_q[k], first + narrator_pkg::flash_addr_t'(k));
    if (sample_q.size() != nwords * `NARR_DATA_W)
      abort_run($sformatf("Expected %0d strobes but saw %0d",
                          nwords * `NARR_DATA_W, sample_q.size()));
    for (k = 0; k < nwords; k++)
    begin
      w = word_at(first + narrator_pkg::flash_addr_t'(k));
      for (b = 0; b < `NARR_DATA_W; b++)
      begin
        exp = silent ? 8'sd0 : (w[b] ? 8'sd127 : -8'sd128);
        check_sample("audio_sample", sample_q[k * `NARR_DATA_W + b], exp);
      end
    end
  endtask

  task automatic play_letter(input narrator_pkg::ascii_t c);
    int idx;
    idx = int'(c) - int'(8'h61);
    play_range(c, narrator_pkg::flash_addr_t'(idx * `NARR_PHONEME_STRIDE),
               `NARR_LOWEST_PHONEME_WORDS + (idx % 4), 1'b0);
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic test_reset_state();
    int n;
    n = 0;
    while (arst_n !== 1'b1)
    begin
      @(negedge CLK_50M);
      n++;
      if (n > 100)
        abort_run("Reset was never released");
    end
    @(negedge CLK_50M);
    check_bit("key_ready", key_ready, 1'b1);
    check_div("sample_div", sample_div, `NARR_DIV_DEFAULT);
    check_bit("flash_read", flash_read, 1'b0);
    check_bit("sample_strobe", sample_strobe, 1'b0);
    check_sample("audio_sample", audio_sample, 8'sd0);
  endtask

  task automatic test_dropped_char();
    int n;
    accepted_q.delete();
    send_key("7");
    for (n = 0; n < 200; n++)
    begin
      check_bit("key_ready", key_ready, 1'b1);
      if (flash_read)
        abort_run("A flash read started after a dropped character");
      @(negedge CLK_50M);
    end
  endtask

  task automatic test_speed();
    narrator_pkg::sample_div_t exp_div;
    int next_div;
    int k;
    exp_div = `NARR_DIV_DEFAULT;
    for (k = 0; k < 3; k++)
    begin
      press_button(0);
      next_div = int'(exp_div) - `NARR_DIV_STEP;
      if (next_div < `NARR_DIV_MIN)
        next_div = `NARR_DIV_MIN;
      exp_div = narrator_pkg::sample_div_t'(next_div);
      check_div("sample_div", sample_div, exp_div);
    end
    check_div("sample_div", sample_div, `NARR_DIV_DEFAULT - 3 * `NARR_DIV_STEP);
    // Enough presses to hit the upper limit from here
    for (k = 0; k < 30; k++)
    begin
      press_button(1);
      next_div = int'(exp_div) + `NARR_DIV_STEP;
      if (next_div > `NARR_DIV_MAX)
        next_div = `NARR_DIV_MAX;
      exp_div = narrator_pkg::sample_div_t'(next_div);
      check_div("sample_div", sample_div, exp_div);
    end
    check_div("sample_div", sample_div, `NARR_DIV_MAX);
    press_button(2);
    check_div("sample_div", sample_div, `NARR_DIV_DEFAULT);
    play_letter("a");
    for (k = 1; k < strobe_cyc_q.size(); k++)
    begin
      if (strobe_cyc_q[k] - strobe_cyc_q[k-1] < int'(sample_div))
        abort_run($sformatf("ERROR t=%0t strobe spacing: got %0d, expected at least %0d",
                            $time, strobe_cyc_q[k] - strobe_cyc_q[k-1], sample_div));
    end
  endtask

  initial
  begin
    key_valid = 1'b0;
    key_char = '0;
    btn_up = 1'b0;
    btn_down = 1'b0;
    btn_reset = 1'b0;

    test_reset_state();
    play_letter("c");
    // Space plays phoneme 0 silently
    play_range(" ", '0, `NARR_LOWEST_PHONEME_WORDS, 1'b1);
    test_dropped_char();
    test_speed();
    // Long waitrequest and data stalls
    stall_max = 15;
    play_letter("d");
    stall_max = 3;

    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- narrator.f
+incdir+source
source/narrator_pkg.sv
source/narrator_ifs.sv
source/phoneme_sequencer.sv
source/flash_reader.sv
source/sample_player.sv
source/sample_rate_ctrl.sv
source/narrator_top.sv
verification/tb_clock_gen.sv
verification/narrator_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the narrator testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f narrator.f \
  --top-module narrator_tb -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vnarrator_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "ERRORS FOUND" "$SIM_LOG"; then
  echo "Simulation reported failure"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0
